//--- lj_eval_testdata.txt
# Columns: W addr data | R addr data resp | P ref_id nbr_id rx ry rz nx ny nz
# E ref_id nbr_id fx fy fz | B toggles back-pressure; addr, data and ids hex, the rest decimal
# Register access after reset
R 000 00000000 0
W 004 005f5e10
R 004 005f5e10 0
W 000 00000001
R 000 00000001 0
R 010 00000000 2
# Coefficients for bins 0, 1, 2 and 5, bin 3 left at zero
W 100 00000064
W 104 0000fffd
W 108 00000007
W 114 000003e8
W 200 00000000
# Force rule across bins
P 010001 010002 100 200 -50 90 180 -40
E 010001 010002 1000 2000 -1000
P 010003 020004 1000 0 0 -100 0 0
E 010003 020004 -3300 0 0
P 030005 030006 0 0 0 800 -900 300
E 030005 030006 2400 -2700 900
P 040007 040008 -1000 5 0 500 5 -500
E 040007 040008 -10500 0 3500
P 050009 05000a 900 -7 3 -900 -7 3
E 050009 05000a 0 0 0
# Cutoff of 6250000, beyond it and exactly on it are dropped
P 06000b 06000c 1500 0 0 -1500 0 0
P 06000d 06000e 1250 0 0 -1250 0 0
P 06000f 060010 1250 0 0 -1249 0 0
E 06000f 060010 2499000 0 0
P 070011 070012 1000 1000 500 -500 -500 -500
E 070011 070012 1500000 1500000 1000000
R 008 00000009 0
R 00c 00000007 0
# Clear the counters and run under random back-pressure
W 000 00000003
B
P 1a0001 1b0002 10 20 30 0 0 0
E 1a0001 1b0002 1000 2000 3000
P 1a0003 1b0004 0 0 0 1100 0 0
E 1a0003 1b0004 3300 0 0
P 1a0005 1b0006 2000 0 0 -1000 0 0
P 1a0007 1b0008 -5 -6 -7 5 6 7
E 1a0007 1b0008 -1000 -1200 -1400
P 1a0009 1b000a 1200 -300 100 -300 300 -400
E 1a0009 1b000a 10500 -4200 3500
P 1a000b 1b000c 7 7 7 0 0 0
E 1a000b 1b000c 700 700 700
B
R 008 00000006 0
R 00c 00000005 0
# Disabled path holds the pair until enable returns
W 000 00000000
P 1f0001 1f0002 3 0 0 0 4 0
R 008 00000006 0
W 000 00000001
E 1f0001 1f0002 300 -400 0
R 008 00000007 0
R 00c 00000006 0

//--- flist.f
+incdir+.
lj_pkg.sv
pair_fifo.sv
pair_filter.sv
lj_force_pipe.sv
lj_config_regs.sv
lj_eval_top.sv
lj_eval_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the LJ evaluator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module lj_eval_tb -o lj_eval_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/lj_eval_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

//--- lj_eval_tb.sv
`timescale 1ns/1ns
// Self-checking testbench for the LJ pair force evaluator
// Register, pair and expected-result commands come from lj_eval_testdata.txt
// Pairs and results run against the DUT from queues in a background stream process
`include "lj_macros.svh"

module lj_eval_tb;
	import lj_pkg::*;

	localparam int CYCLES_PER_LINE = 200;
	// No-stall path latency plus one cycle
	localparam int SETTLE_CYCLES = 8;

	typedef struct packed {
		pid_t ref_id;
		pid_t nbr_id;
		pos_t ref_x;
		pos_t ref_y;
		pos_t ref_z;
		pos_t nbr_x;
		pos_t nbr_y;
		pos_t nbr_z;
	} pair_rec_t;

	typedef struct packed {
		pid_t ref_id;
		pid_t nbr_id;
		force_t fx;
		force_t fy;
		force_t fz;
	} result_rec_t;

	logic clock;
	logic rst;
	logic ivalid;
	logic oready;
	logic iready;
	logic ovalid;
	pid_t in_ref_id;
	pid_t in_nbr_id;
	pos_t in_ref_x;
	pos_t in_ref_y;
	pos_t in_ref_z;
	pos_t in_nbr_x;
	pos_t in_nbr_y;
	pos_t in_nbr_z;
	pid_t out_ref_id;
	pid_t out_nbr_id;
	force_t out_fx;
	force_t out_fy;
	force_t out_fz;
	logic [`LJ_AXI_ADDR_W-1:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [`LJ_AXI_DATA_W-1:0] s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [`LJ_AXI_ADDR_W-1:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [`LJ_AXI_DATA_W-1:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;

	// Stimulus and scoreboard state
	pair_rec_t pair_q[$];
	result_rec_t exp_q[$];
	integer seed = 95127;
	int n_lines = 0;
	logic run_en = 1'b0;
	logic bp_on = 1'b0;
	// Enable as the test data last wrote it
	logic expect_en = 1'b0;
	logic ctrl_busy = 1'b0;

	lj_eval_top dut_i (.*);

	always #20 clock = ~clock;

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("[FAIL] t=%0t %s", $time, msg);
		abort_run();
	endtask

	task automatic require_fields(input int code, input int want);
		if (code != want) begin
			$display("Malformed command line in the test data file");
			abort_run();
		end
	endtask

	// Four registers plus one word per table bin are mapped
	function automatic logic [1:0] bresp_for(input logic [`LJ_AXI_ADDR_W-1:0] a);
		if (a == `LJ_REG_CTRL || a == `LJ_REG_CUTOFF ||
				a == `LJ_REG_PAIRS_IN || a == `LJ_REG_PAIRS_KEPT) begin
			return 2'b00;
		end
		if (int'(a) >= int'(`LJ_TABLE_BASE) &&
				int'(a) < int'(`LJ_TABLE_BASE) + 4 * `LJ_BIN_NUM && a[1:0] == 2'b00) begin
			return 2'b00;
		end
		return 2'b10;
	endfunction

	task automatic axi_write(input logic [`LJ_AXI_ADDR_W-1:0] addr,
			input logic [`LJ_AXI_DATA_W-1:0] data, output logic [1:0] resp);
		logic aw_done;
		logic w_done;
		logic b_seen;
		aw_done = 1'b0;
		w_done = 1'b0;
		b_seen = 1'b0;
		resp = 2'b00;
		@(posedge clock);
		#2;
		s_axi_awaddr = addr;
		s_axi_awvalid = 1'b1;
		s_axi_wdata = data;
		s_axi_wstrb = 4'hf;
		s_axi_wvalid = 1'b1;
		s_axi_bready = 1'b1;
		while (!b_seen) begin
			@(negedge clock);
			aw_done = aw_done || (s_axi_awvalid && s_axi_awready);
			w_done = w_done || (s_axi_wvalid && s_axi_wready);
			if (s_axi_bvalid) begin
				b_seen = 1'b1;
				resp = s_axi_bresp;
			end
			@(posedge clock);
			#2;
			// Each channel drops valid once accepted
			s_axi_awvalid = !aw_done;
			s_axi_wvalid = !w_done;
		end
		s_axi_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`LJ_AXI_ADDR_W-1:0] addr,
			output logic [`LJ_AXI_DATA_W-1:0] data, output logic [1:0] resp);
		logic ar_done;
		logic r_seen;
		ar_done = 1'b0;
		r_seen = 1'b0;
		data = '0;
		resp = 2'b00;
		@(posedge clock);
		#2;
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		s_axi_rready = 1'b1;
		while (!r_seen) begin
			@(negedge clock);
			ar_done = ar_done || (s_axi_arvalid && s_axi_arready);
			if (s_axi_rvalid) begin
				r_seen = 1'b1;
				data = s_axi_rdata;
				resp = s_axi_rresp;
			end
			@(posedge clock);
			#2;
			s_axi_arvalid = !ar_done;
		end
		s_axi_rready = 1'b0;
	endtask

	// Wait until all queued results are seen and dropped pairs have left the filter
	task automatic wait_for_idle();
		while (!((pair_q.size() == 0 || !expect_en) && exp_q.size() == 0)) begin
			@(posedge clock);
		end
		repeat (SETTLE_CYCLES) @(posedge clock);
	endtask

	// Pair driver, iready source and output checker
	initial begin : stream
		result_rec_t seen;
		result_rec_t held;
		result_rec_t want;
		logic hold_pending;
		hold_pending = 1'b0;
		held = '0;
		wait (run_en);
		forever begin
			@(posedge clock);
			#2;
			if (pair_q.size() > 0) begin
				ivalid = 1'b1;
				{in_ref_id, in_nbr_id, in_ref_x, in_ref_y, in_ref_z,
					in_nbr_x, in_nbr_y, in_nbr_z} = pair_q[0];
			end else begin
				ivalid = 1'b0;
			end
			iready = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
			// Sample mid-cycle once everything has settled
			@(negedge clock);
			seen = {out_ref_id, out_nbr_id, out_fx, out_fy, out_fz};
			if (ivalid && oready) begin
				void'(pair_q.pop_front());
			end
			if (!ctrl_busy && !expect_en) begin
				assert (!oready) else begin
					report_mismatch("oready high while the path is disabled");
				end
			end
			// Stalled output must not move
			if (hold_pending) begin
				assert (ovalid && seen == held) else begin
					report_mismatch("output changed while iready was low");
				end
			end
			hold_pending = ovalid && !iready;
			held = seen;
			if (ovalid && iready) begin
				if (exp_q.size() == 0) begin
					$display("Result for ids %06h %06h arrived with none expected",
						seen.ref_id, seen.nbr_id);
					abort_run();
				end else begin
					want = exp_q.pop_front();
					assert (seen == want) else begin
						report_mismatch($sformatf(
							"got %06h %06h %0d %0d %0d, want %06h %06h %0d %0d %0d",
							seen.ref_id, seen.nbr_id, seen.fx, seen.fy, seen.fz,
							want.ref_id, want.nbr_id, want.fx, want.fy, want.fz));
					end
				end
			end
		end
	end

	initial begin : watchdog
		wait (n_lines > 0);
		repeat (n_lines * CYCLES_PER_LINE) @(posedge clock);
		$display("Timeout: test data not finished after %0d cycles",
			n_lines * CYCLES_PER_LINE);
		abort_run();
	end

	initial begin : main
		int fd;
		int code;
		int lines;
		int num [6];
		logic [63:0] cmd;
		logic [2047:0] line_buf;
		logic [`LJ_AXI_ADDR_W-1:0] addr;
		logic [`LJ_AXI_DATA_W-1:0] data;
		logic [`LJ_AXI_DATA_W-1:0] got;
		logic [1:0] resp;
		logic [1:0] want_resp;
		pid_t id_a;
		pid_t id_b;
		clock = 1'b0;
		rst = 1'b1;
		ivalid = 1'b0;
		iready = 1'b1;
		{in_ref_id, in_nbr_id, in_ref_x, in_ref_y, in_ref_z} = '0;
		{in_nbr_x, in_nbr_y, in_nbr_z} = '0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = 4'h0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		lines = 0;

		// Line count sizes the watchdog
		fd = $fopen("lj_eval_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test data file");
			abort_run();
		end
		while (!$feof(fd)) begin
			code = $fgets(line_buf, fd);
			if (code > 0) begin
				lines++;
			end
		end
		$fclose(fd);
		if (lines == 0) begin
			$display("The test data file is empty");
			abort_run();
		end
		n_lines = lines;

		repeat (4) @(posedge clock);
		#2;
		rst = 1'b0;
		#1;
		assert (!oready && !ovalid) else begin
			report_mismatch("oready or ovalid high after reset");
		end
		run_en = 1'b1;

		fd = $fopen("lj_eval_testdata.txt", "r");
		forever begin
			code = $fscanf(fd, " %s", cmd);
			if (code != 1) begin
				break;
			end
			case (cmd)
				"#": begin
					code = $fgets(line_buf, fd);
				end
				"W": begin
					code = $fscanf(fd, " %h %h", addr, data);
					require_fields(code, 2);
					want_resp = bresp_for(addr);
					ctrl_busy = (addr == `LJ_REG_CTRL);
					axi_write(addr, data, resp);
					ctrl_busy = 1'b0;
					assert (resp == want_resp) else begin
						report_mismatch($sformatf("write 0x%03h bresp %0d, expected %0d",
							addr, resp, want_resp));
					end
					if (addr == `LJ_REG_CTRL) begin
						expect_en = data[0];
					end
				end
				"R": begin
					code = $fscanf(fd, " %h %h %d", addr, data, num[0]);
					require_fields(code, 3);
					wait_for_idle();
					axi_read(addr, got, resp);
					assert (got == data && resp == 2'(num[0])) else begin
						report_mismatch($sformatf(
							"read 0x%03h gave %08h resp %0d, expected %08h resp %0d",
							addr, got, resp, data, num[0]));
					end
				end
				"P": begin
					code = $fscanf(fd, " %h %h %d %d %d %d %d %d", id_a, id_b,
						num[0], num[1], num[2], num[3], num[4], num[5]);
					require_fields(code, 8);
					pair_q.push_back({id_a, id_b, pos_t'(num[0]), pos_t'(num[1]),
						pos_t'(num[2]), pos_t'(num[3]), pos_t'(num[4]), pos_t'(num[5])});
				end
				"E": begin
					code = $fscanf(fd, " %h %h %d %d %d", id_a, id_b, num[0], num[1], num[2]);
					require_fields(code, 5);
					exp_q.push_back({id_a, id_b, force_t'(num[0]), force_t'(num[1]),
						force_t'(num[2])});
				end
				"B": begin
					// Queued traffic runs under back-pressure until it drains
					if (bp_on) begin
						wait_for_idle();
					end
					bp_on = !bp_on;
				end
				default: begin
					$display("Unknown command in the test data file");
					abort_run();
				end
			endcase
		end
		$fclose(fd);

		wait_for_idle();
		if (pair_q.size() != 0 || exp_q.size() != 0) begin
			$display("Pairs or expected results left over at the end of the test data");
			abort_run();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- lj_eval_top.sv
`timescale 1ns/1ns
// Top of the streaming LJ pair force evaluator
// Upstream hands pairs on ivalid and oready, downstream takes forces on ovalid and iready
// Config and coefficient table sit behind the AXI4-Lite port
`include "lj_macros.svh"

module lj_eval_top (
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      ivalid,
	output logic                      oready,
	input  logic                      iready,
	output logic                      ovalid,
	input  lj_pkg::pid_t              in_ref_id,
	input  lj_pkg::pid_t              in_nbr_id,
	input  lj_pkg::pos_t              in_ref_x,
	input  lj_pkg::pos_t              in_ref_y,
	input  lj_pkg::pos_t              in_ref_z,
	input  lj_pkg::pos_t              in_nbr_x,
	input  lj_pkg::pos_t              in_nbr_y,
	input  lj_pkg::pos_t              in_nbr_z,
	output lj_pkg::pid_t              out_ref_id,
	output lj_pkg::pid_t              out_nbr_id,
	output lj_pkg::force_t            out_fx,
	output lj_pkg::force_t            out_fy,
	output lj_pkg::force_t            out_fz,
	input  logic [`LJ_AXI_ADDR_W-1:0] s_axi_awaddr,
	input  logic                      s_axi_awvalid,
	output logic                      s_axi_awready,
	input  logic [`LJ_AXI_DATA_W-1:0] s_axi_wdata,
	input  logic [3:0]                s_axi_wstrb,
	input  logic                      s_axi_wvalid,
	output logic                      s_axi_wready,
	output logic [1:0]                s_axi_bresp,
	output logic                      s_axi_bvalid,
	input  logic                      s_axi_bready,
	input  logic [`LJ_AXI_ADDR_W-1:0] s_axi_araddr,
	input  logic                      s_axi_arvalid,
	output logic                      s_axi_arready,
	output logic [`LJ_AXI_DATA_W-1:0] s_axi_rdata,
	output logic [1:0]                s_axi_rresp,
	output logic                      s_axi_rvalid,
	input  logic                      s_axi_rready
);
	import lj_pkg::*;

	// Buffer words, MSB first
	// Input is ids then reference xyz then neighbor xyz
	// Output is ids then force xyz
	localparam int IN_W = 2 * $bits(pid_t) + 6 * $bits(pos_t);
	localparam int OUT_W = 2 * $bits(pid_t) + 3 * $bits(force_t);

	logic [IN_W-1:0] in_rd_data;
	logic in_full;
	logic in_empty;
	logic in_rd_valid;
	logic in_rd_en;
	pid_t buf_ref_id;
	pid_t buf_nbr_id;
	pos_t buf_ref_x;
	pos_t buf_ref_y;
	pos_t buf_ref_z;
	pos_t buf_nbr_x;
	pos_t buf_nbr_y;
	pos_t buf_nbr_z;

	// Filter to force pipeline
	logic flt_valid;
	pid_t flt_ref_id;
	pid_t flt_nbr_id;
	disp_t flt_dx;
	disp_t flt_dy;
	disp_t flt_dz;
	r2_t flt_r2;

	// Force pipeline to output buffer
	logic out_wr_en;
	pid_t pipe_ref_id;
	pid_t pipe_nbr_id;
	force_t pipe_fx;
	force_t pipe_fy;
	force_t pipe_fz;
	logic [OUT_W-1:0] out_rd_data;
	logic out_full;
	logic out_empty;

	// Compute path freezes while the output buffer is full
	logic advance;

	// Config
	logic enable;
	r2_t cutoff_2;
	logic tab_we;
	bin_t tab_addr;
	coef_t tab_data;
	logic pair_in;
	logic pair_kept;

	assign oready = enable && !in_full;
	assign in_rd_valid = !in_empty;
	assign {buf_ref_id, buf_nbr_id, buf_ref_x, buf_ref_y, buf_ref_z,
		buf_nbr_x, buf_nbr_y, buf_nbr_z} = in_rd_data;

	assign advance = !out_full;
	assign ovalid = !out_empty;
	assign {out_ref_id, out_nbr_id, out_fx, out_fy, out_fz} = out_rd_data;

	pair_fifo #(
		.WIDTH (IN_W),
		.DEPTH (`LJ_IN_DEPTH)
	) in_buf_i (
		.clock   (clock),
		.rst     (rst),
		.wr_en   (ivalid && oready),
		.wr_data ({in_ref_id, in_nbr_id, in_ref_x, in_ref_y, in_ref_z,
			in_nbr_x, in_nbr_y, in_nbr_z}),
		.rd_en   (in_rd_en),
		.rd_data (in_rd_data),
		.full    (in_full),
		.empty   (in_empty)
	);

	pair_filter filter_i (
		.clock      (clock),
		.rst        (rst),
		.advance    (advance),
		.in_valid   (in_rd_valid),
		.in_ref_id  (buf_ref_id),
		.in_nbr_id  (buf_nbr_id),
		.in_ref_x   (buf_ref_x),
		.in_ref_y   (buf_ref_y),
		.in_ref_z   (buf_ref_z),
		.in_nbr_x   (buf_nbr_x),
		.in_nbr_y   (buf_nbr_y),
		.in_nbr_z   (buf_nbr_z),
		.cutoff_2   (cutoff_2),
		.in_pop     (in_rd_en),
		.flt_valid  (flt_valid),
		.flt_ref_id (flt_ref_id),
		.flt_nbr_id (flt_nbr_id),
		.flt_dx     (flt_dx),
		.flt_dy     (flt_dy),
		.flt_dz     (flt_dz),
		.flt_r2     (flt_r2),
		.pair_in    (pair_in),
		.pair_kept  (pair_kept)
	);

	lj_force_pipe force_i (
		.clock      (clock),
		.rst        (rst),
		.advance    (advance),
		.flt_valid  (flt_valid),
		.flt_ref_id (flt_ref_id),
		.flt_nbr_id (flt_nbr_id),
		.flt_dx     (flt_dx),
		.flt_dy     (flt_dy),
		.flt_dz     (flt_dz),
		.flt_r2     (flt_r2),
		.tab_we     (tab_we),
		.tab_addr   (tab_addr),
		.tab_data   (tab_data),
		.out_wr_en  (out_wr_en),
		.out_ref_id (pipe_ref_id),
		.out_nbr_id (pipe_nbr_id),
		.out_fx     (pipe_fx),
		.out_fy     (pipe_fy),
		.out_fz     (pipe_fz)
	);

	// Pops when downstream takes the head result
	pair_fifo #(
		.WIDTH (OUT_W),
		.DEPTH (`LJ_OUT_DEPTH)
	) out_buf_i (
		.clock   (clock),
		.rst     (rst),
		.wr_en   (out_wr_en),
		.wr_data ({pipe_ref_id, pipe_nbr_id, pipe_fx, pipe_fy, pipe_fz}),
		.rd_en   (ovalid && iready),
		.rd_data (out_rd_data),
		.full    (out_full),
		.empty   (out_empty)
	);

	lj_config_regs regs_i (
		.clock         (clock),
		.rst           (rst),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.pair_in       (pair_in),
		.pair_kept     (pair_kept),
		.enable        (enable),
		.cutoff_2      (cutoff_2),
		.tab_we        (tab_we),
		.tab_addr      (tab_addr),
		.tab_data      (tab_data)
	);

endmodule

//--- lj_config_regs.sv
`timescale 1ns/1ns
// AXI4-Lite register block for the LJ evaluator
// Holds enable and cutoff, counts received and kept pairs
// Writes into the table window become single-cycle table writes
`include "lj_macros.svh"

module lj_config_regs (
	input  logic                      clock,
	input  logic                      rst,
	input  logic [`LJ_AXI_ADDR_W-1:0] s_axi_awaddr,
	input  logic                      s_axi_awvalid,
	output logic                      s_axi_awready,
	input  logic [`LJ_AXI_DATA_W-1:0] s_axi_wdata,
	input  logic [3:0]                s_axi_wstrb,
	input  logic                      s_axi_wvalid,
	output logic                      s_axi_wready,
	output logic [1:0]                s_axi_bresp,
	output logic                      s_axi_bvalid,
	input  logic                      s_axi_bready,
	input  logic [`LJ_AXI_ADDR_W-1:0] s_axi_araddr,
	input  logic                      s_axi_arvalid,
	output logic                      s_axi_arready,
	output logic [`LJ_AXI_DATA_W-1:0] s_axi_rdata,
	output logic [1:0]                s_axi_rresp,
	output logic                      s_axi_rvalid,
	input  logic                      s_axi_rready,
	input  logic                      pair_in,
	input  logic                      pair_kept,
	output logic                      enable,
	output lj_pkg::r2_t               cutoff_2,
	output logic                      tab_we,
	output lj_pkg::bin_t              tab_addr,
	output lj_pkg::coef_t             tab_data
);
	import lj_pkg::*;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// Write address and data are captured independently
	logic aw_held;
	logic w_held;
	logic [`LJ_AXI_ADDR_W-1:0] aw_addr;
	logic [`LJ_AXI_DATA_W-1:0] w_data;
	logic [3:0] w_strb;
	logic wr_fire;
	logic hit_ctrl;
	logic hit_cutoff;
	logic hit_count;
	logic hit_table;
	logic [`LJ_AXI_DATA_W-1:0] ctrl_new;
	logic [`LJ_AXI_DATA_W-1:0] cutoff_q;
	logic cnt_clr;
	logic [31:0] pairs_in_q;
	logic [31:0] pairs_kept_q;
	logic [`LJ_AXI_DATA_W-1:0] rd_value;
	logic rd_hit;

	// Byte lane merge under wstrb
	function automatic logic [`LJ_AXI_DATA_W-1:0] merge(
		input logic [`LJ_AXI_DATA_W-1:0] old,
		input logic [`LJ_AXI_DATA_W-1:0] data,
		input logic [3:0] strb
	);
		logic [`LJ_AXI_DATA_W-1:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = data[8*b +: 8];
			end
		end
		return res;
	endfunction

	assign s_axi_awready = !aw_held;
	assign s_axi_wready = !w_held;
	assign s_axi_arready = !s_axi_rvalid;

	// Commit once both halves are in and the last response has gone
	assign wr_fire = aw_held && w_held && !s_axi_bvalid;

	// Write decode
	assign hit_ctrl = (aw_addr == `LJ_REG_CTRL);
	assign hit_cutoff = (aw_addr == `LJ_REG_CUTOFF);
	// Counters accept writes and ignore them
	assign hit_count = (aw_addr == `LJ_REG_PAIRS_IN) || (aw_addr == `LJ_REG_PAIRS_KEPT);
	assign hit_table = (aw_addr >= `LJ_TABLE_BASE) &&
		(aw_addr < `LJ_TABLE_BASE + 4 * `LJ_BIN_NUM) && (aw_addr[1:0] == 2'b00);
	assign ctrl_new = merge(`LJ_AXI_DATA_W'(enable), w_data, w_strb);

	assign cutoff_2 = r2_t'(cutoff_q);

	// Read decode
	always_comb begin
		rd_hit = 1'b1;
		case (s_axi_araddr)
			`LJ_REG_CTRL: rd_value = `LJ_AXI_DATA_W'(enable);
			`LJ_REG_CUTOFF: rd_value = cutoff_q;
			`LJ_REG_PAIRS_IN: rd_value = pairs_in_q;
			`LJ_REG_PAIRS_KEPT: rd_value = pairs_kept_q;
			default: begin
				rd_value = '0;
				rd_hit = 1'b0;
			end
		endcase
	end

	// Write channel capture
	always_ff @(posedge clock) begin
		if (s_axi_awvalid && s_axi_awready) begin
			aw_addr <= s_axi_awaddr;
		end
		if (s_axi_wvalid && s_axi_wready) begin
			w_data <= s_axi_wdata;
			w_strb <= s_axi_wstrb;
		end
	end

	// Write handshake, registers and table port
	always_ff @(posedge clock) begin
		if (rst) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			s_axi_bvalid <= 1'b0;
			s_axi_bresp <= RESP_OKAY;
			enable <= 1'b0;
			cutoff_q <= '0;
			cnt_clr <= 1'b0;
			tab_we <= 1'b0;
		end else begin
			cnt_clr <= 1'b0;
			tab_we <= 1'b0;
			if (s_axi_awvalid && s_axi_awready) begin
				aw_held <= 1'b1;
			end
			if (s_axi_wvalid && s_axi_wready) begin
				w_held <= 1'b1;
			end
			if (s_axi_bvalid && s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
			end
			if (wr_fire) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				s_axi_bvalid <= 1'b1;
				s_axi_bresp <= (hit_ctrl || hit_cutoff || hit_count || hit_table) ?
					RESP_OKAY : RESP_SLVERR;
				if (hit_ctrl) begin
					enable <= ctrl_new[0];
					// Self-clearing
					cnt_clr <= ctrl_new[1];
				end
				if (hit_cutoff) begin
					cutoff_q <= merge(cutoff_q, w_data, w_strb);
				end
				tab_we <= hit_table;
			end
		end
	end

	// Table word offset and data
	always_ff @(posedge clock) begin
		if (wr_fire && hit_table) begin
			tab_addr <= bin_t'((aw_addr - `LJ_TABLE_BASE) >> 2);
			tab_data <= coef_t'(w_data);
		end
	end

	// Pair counters wrap at 32 bits
	always_ff @(posedge clock) begin
		if (rst || cnt_clr) begin
			pairs_in_q <= '0;
			pairs_kept_q <= '0;
		end else begin
			pairs_in_q <= pairs_in_q + 32'(pair_in);
			pairs_kept_q <= pairs_kept_q + 32'(pair_kept);
		end
	end

	// Read channel
	always_ff @(posedge clock) begin
		if (rst) begin
			s_axi_rvalid <= 1'b0;
			s_axi_rresp <= RESP_OKAY;
		end else if (s_axi_arvalid && s_axi_arready) begin
			s_axi_rvalid <= 1'b1;
			s_axi_rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end else if (s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
		end
	end

	// Read data
	always_ff @(posedge clock) begin
		if (s_axi_arvalid && s_axi_arready) begin
			s_axi_rdata <= rd_value;
		end
	end

endmodule

//--- lj_force_pipe.sv
`timescale 1ns/1ns
// LJ force pipeline with its coefficient table
// Stage A looks up the r2 bin, stage B multiplies, stage C registers the result
// The table is written from the config block at any time
`include "lj_macros.svh"

module lj_force_pipe (
	input  logic           clock,
	input  logic           rst,
	input  logic           advance,
	input  logic           flt_valid,
	input  lj_pkg::pid_t   flt_ref_id,
	input  lj_pkg::pid_t   flt_nbr_id,
	input  lj_pkg::disp_t  flt_dx,
	input  lj_pkg::disp_t  flt_dy,
	input  lj_pkg::disp_t  flt_dz,
	input  lj_pkg::r2_t    flt_r2,
	input  logic           tab_we,
	input  lj_pkg::bin_t   tab_addr,
	input  lj_pkg::coef_t  tab_data,
	output logic           out_wr_en,
	output lj_pkg::pid_t   out_ref_id,
	output lj_pkg::pid_t   out_nbr_id,
	output lj_pkg::force_t out_fx,
	output lj_pkg::force_t out_fy,
	output lj_pkg::force_t out_fz
);
	import lj_pkg::*;

	coef_t coef_tab [`LJ_BIN_NUM];
	bin_t bin;

	// Stage A
	logic a_valid;
	pid_t a_ref_id;
	pid_t a_nbr_id;
	coef_t a_coef;
	disp_t a_dx;
	disp_t a_dy;
	disp_t a_dz;

	// Stage B
	logic b_valid;
	pid_t b_ref_id;
	pid_t b_nbr_id;
	force_t b_fx;
	force_t b_fy;
	force_t b_fz;

	// Stage C valid, payload sits on the out_* ports
	logic c_valid;

	// Sign extended coefficient times displacement
	function automatic force_t scale(input coef_t c, input disp_t d);
		return force_t'(c) * force_t'(d);
	endfunction

	// Upper r2 bits select the bin
	assign bin = bin_t'(flt_r2 >> `LJ_BIN_SHIFT);

	// Only a moving pipeline hands a result to the output buffer
	assign out_wr_en = advance && c_valid;

	// Coefficient table
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `LJ_BIN_NUM; i++) begin
				coef_tab[i] <= '0;
			end
		end else if (tab_we) begin
			coef_tab[tab_addr] <= tab_data;
		end
	end

	// Valid chain
	always_ff @(posedge clock) begin
		if (rst) begin
			a_valid <= 1'b0;
			b_valid <= 1'b0;
			c_valid <= 1'b0;
		end else if (advance) begin
			a_valid <= flt_valid;
			b_valid <= a_valid;
			c_valid <= b_valid;
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (advance) begin
			// Lookup
			a_ref_id <= flt_ref_id;
			a_nbr_id <= flt_nbr_id;
			a_coef <= coef_tab[bin];
			a_dx <= flt_dx;
			a_dy <= flt_dy;
			a_dz <= flt_dz;
			// Multiply
			b_ref_id <= a_ref_id;
			b_nbr_id <= a_nbr_id;
			b_fx <= scale(a_coef, a_dx);
			b_fy <= scale(a_coef, a_dy);
			b_fz <= scale(a_coef, a_dz);
			// Output register
			out_ref_id <= b_ref_id;
			out_nbr_id <= b_nbr_id;
			out_fx <= b_fx;
			out_fy <= b_fy;
			out_fz <= b_fz;
		end
	end

endmodule

//--- pair_filter.sv
`timescale 1ns/1ns
// Two-stage cutoff filter between the input buffer and the force pipeline
// Stage 1 forms the displacement, stage 2 forms r2 and drops far pairs
// Everything moves only on advance
module pair_filter (
	input  logic          clock,
	input  logic          rst,
	input  logic          advance,
	input  logic          in_valid,
	input  lj_pkg::pid_t  in_ref_id,
	input  lj_pkg::pid_t  in_nbr_id,
	input  lj_pkg::pos_t  in_ref_x,
	input  lj_pkg::pos_t  in_ref_y,
	input  lj_pkg::pos_t  in_ref_z,
	input  lj_pkg::pos_t  in_nbr_x,
	input  lj_pkg::pos_t  in_nbr_y,
	input  lj_pkg::pos_t  in_nbr_z,
	input  lj_pkg::r2_t   cutoff_2,
	output logic          in_pop,
	output logic          flt_valid,
	output lj_pkg::pid_t  flt_ref_id,
	output lj_pkg::pid_t  flt_nbr_id,
	output lj_pkg::disp_t flt_dx,
	output lj_pkg::disp_t flt_dy,
	output lj_pkg::disp_t flt_dz,
	output lj_pkg::r2_t   flt_r2,
	output logic          pair_in,
	output logic          pair_kept
);
	import lj_pkg::*;

	logic s1_valid;
	pid_t s1_ref_id;
	pid_t s1_nbr_id;
	disp_t s1_dx;
	disp_t s1_dy;
	disp_t s1_dz;
	r2_t s2_r2;
	filter_state_e state;

	// Square of a displacement, never negative
	function automatic r2_t square(input disp_t d);
		logic signed [2*$bits(disp_t)-1:0] p;
		p = d * d;
		return r2_t'(p);
	endfunction

	// Pop from the input buffer whenever the path moves and a pair waits
	assign in_pop = advance && in_valid;
	assign pair_in = in_pop;

	assign s2_r2 = square(s1_dx) + square(s1_dy) + square(s1_dz);

	// Stage 2 output was reloaded at the last edge only when state is RUN
	// so a kept pair is counted once even across a long hold
	assign pair_kept = flt_valid && (state == FLT_RUN);

	// Control
	always_ff @(posedge clock) begin
		if (rst) begin
			s1_valid <= 1'b0;
			flt_valid <= 1'b0;
			state <= FLT_HOLD;
		end else begin
			state <= advance ? FLT_RUN : FLT_HOLD;
			if (advance) begin
				s1_valid <= in_valid;
				// Strictly inside the cutoff
				flt_valid <= s1_valid && (s2_r2 < cutoff_2);
			end
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (advance) begin
			s1_ref_id <= in_ref_id;
			s1_nbr_id <= in_nbr_id;
			// Reference minus neighbor
			s1_dx <= disp_t'(in_ref_x) - disp_t'(in_nbr_x);
			s1_dy <= disp_t'(in_ref_y) - disp_t'(in_nbr_y);
			s1_dz <= disp_t'(in_ref_z) - disp_t'(in_nbr_z);
			flt_ref_id <= s1_ref_id;
			flt_nbr_id <= s1_nbr_id;
			flt_dx <= s1_dx;
			flt_dy <= s1_dy;
			flt_dz <= s1_dz;
			flt_r2 <= s2_r2;
		end
	end

endmodule

//--- pair_fifo.sv
`timescale 1ns/1ns
// Synchronous FIFO with full and empty flags
// Used for both the input pair buffer and the output force buffer
// The head entry shows on rd_data whenever empty is low
module pair_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic             clock,
	input  logic             rst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_wr;
	logic do_rd;

	// Pointer step with wrap for any depth
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Overflow and underflow requests are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign full = (count == CW'(DEPTH));
	assign empty = (count == '0);
	assign rd_data = mem[rd_ptr];

	// Storage
	always_ff @(posedge clock) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Read and write together leave the count alone
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- lj_pkg.sv
// Types shared by the LJ evaluator RTL and its testbench
// Compile before any module that imports it
`include "lj_macros.svh"

package lj_pkg;

	// Signed particle coordinate
	typedef logic signed [`LJ_POS_W-1:0] pos_t;

	// One extra bit so the difference of two coordinates never overflows
	typedef logic signed [`LJ_POS_W:0] disp_t;

	// Sum of three squared displacements
	typedef logic [2*`LJ_POS_W+1:0] r2_t;

	// Packed cell ids plus address inside the cell
	typedef logic [`LJ_ID_W-1:0] pid_t;

	// Table coefficient and force component
	typedef logic signed [`LJ_COEF_W-1:0] coef_t;
	typedef logic signed [`LJ_FORCE_W-1:0] force_t;

	// Coefficient table index
	typedef logic [$clog2(`LJ_BIN_NUM)-1:0] bin_t;

	// Filter stall tracking
	typedef enum logic {
		FLT_RUN,
		FLT_HOLD
	} filter_state_e;

endpackage

//--- lj_macros.svh
// Widths, buffer sizes, table geometry and register map of the LJ evaluator
// Included by the package and by every module that sizes ports or decodes addresses
`ifndef LJ_MACROS_SVH
`define LJ_MACROS_SVH

// Datapath widths
`define LJ_POS_W          12
`define LJ_ID_W           21
`define LJ_FORCE_W        32
`define LJ_COEF_W         16

// Config bus widths
`define LJ_AXI_ADDR_W     12
`define LJ_AXI_DATA_W     32

// Coefficient table geometry
`define LJ_BIN_NUM        64
`define LJ_BIN_SHIFT      20

// Buffer depths
`define LJ_IN_DEPTH       4
`define LJ_OUT_DEPTH      16

// Byte offsets of the config registers
// CTRL bit 0 enables the path and bit 1 clears the pair counters
`define LJ_REG_CTRL       12'h000
`define LJ_REG_CUTOFF     12'h004
`define LJ_REG_PAIRS_IN   12'h008
`define LJ_REG_PAIRS_KEPT 12'h00C
`define LJ_TABLE_BASE     12'h100

`endif
